// File: build.f
hdl/common_pkg.sv
hdl/tile_in_fifo.sv
hdl/tile_xbar.sv
hdl/mini_core_tile.sv
hdl/fabric.sv
verification/fabric_clk_gen.sv
verification/fabric_tb.sv

// File: Bender.yml
package:
  name: mesh_fabric

sources:
  - hdl/common_pkg.sv
  - hdl/tile_in_fifo.sv
  - hdl/tile_xbar.sv
  - hdl/mini_core_tile.sv
  - hdl/fabric.sv
  - target: test
    files:
      - verification/fabric_clk_gen.sv
      - verification/fabric_tb.sv

// File: verification/fabric_tb.sv
// mesh fabric testbench
`timescale 1ns/100ps
`default_nettype none

module fabric_tb;
    localparam int FIFO_DEPTH = 4;
    localparam int LO = common_pkg::GRID_MIN;
    localparam int HI = common_pkg::GRID_MAX;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    // 81 single, 20 burst, 72 contention, up to 64 stall, 5 edge
    localparam int NUM_TESTS = 6;
    localparam int NUM_TRANS = 81 + 20 + 72 + 64 + 5;
    localparam int WATCHDOG_CYCLES = 10 + 200 * NUM_TESTS + 20 * NUM_TRANS;

    logic                               clk;
    logic                               reset;
    logic                    [3:1][3:1] local_in_valid;
    common_pkg::t_tile_trans [3:1][3:1] local_in;
    common_pkg::t_fab_ready  [3:1][3:1] local_in_ready;
    logic                    [3:1][3:1] local_out_valid;
    common_pkg::t_tile_trans [3:1][3:1] local_out;
    common_pkg::t_fab_ready  [3:1][3:1] local_out_ready;

    // one expected queue per origin and target pair
    common_pkg::t_tile_trans exp_q [81][$];
    logic [7:0]  seq_cnt [1:3][1:3];
    logic [31:0] lfsr_state = 32'he8bb3d6d;
    string       cur_test = "reset";
    int          errors = 0;
    int          err_at_start = 0;
    int          tests_run = 0;
    int          failed_tests = 0;
    int          pending = 0;
    int          received = 0;

    fabric_clk_gen #(
        .PERIOD_NS (4.0)
    ) fabric_clk_gen_inst (
        .clk (clk)
    );

    fabric #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fabric_inst (
        .clk             (clk),
        .reset           (reset),
        .local_in_valid  (local_in_valid),
        .local_in        (local_in),
        .local_in_ready  (local_in_ready),
        .local_out_valid (local_out_valid),
        .local_out       (local_out),
        .local_out_ready (local_out_ready)
    );

    // galois form stepped once per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        end
        return bits;
    endfunction

    function automatic common_pkg::t_tile_id tile_id(input int c, input int r);
        return common_pkg::t_tile_id'{col: 4'(c), row: 4'(r)};
    endfunction

    function automatic bit on_grid(input common_pkg::t_tile_id id);
        return id.col >= LO && id.col <= HI && id.row >= LO && id.row <= HI;
    endfunction

    function automatic int pair_idx(input common_pkg::t_tile_id o, input common_pkg::t_tile_id t);
        return ((o.col - 1) * 3 + o.row - 1) * 9 + (t.col - 1) * 3 + (t.row - 1);
    endfunction

    function automatic common_pkg::t_tile_trans make_trans(input int c, input int r,
                                                           input int tc, input int tr);
        common_pkg::t_tile_trans t;
        t.target = tile_id(tc, tr);
        t.origin = tile_id(c, r);
        t.seq = seq_cnt[c][r];
        t.data = lfsr_bits(32);
        seq_cnt[c][r] = seq_cnt[c][r] + 1'b1;
        return t;
    endfunction

    task automatic mismatch_error(input string what, input logic [55:0] exp,
                                  input logic [55:0] act);
        $display("ERROR %s: %s expected %h, actual %h", cur_test, what, exp, act);
        errors++;
    endtask

    task automatic failure_note(input string msg);
        $display("%s: %s", cur_test, msg);
        errors++;
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors > err_at_start) begin
            failed_tests++;
        end
        $display("%s: %s, %0d errors", cur_test,
                 (errors > err_at_start) ? "failed" : "passed", errors - err_at_start);
    endtask

    // holds valid until each transfer and then idles the port
    task automatic send_stream(input int c, input int r, input int tc, input int tr,
                               input int n);
        for (int i = 0; i < n; i++) begin
            local_in[c][r] = make_trans(c, r, tc, tr);
            local_in_valid[c][r] = 1'b1;
            @(posedge clk);
            while (!local_in_ready[c][r].ready) begin
                @(posedge clk);
            end
            #0.5;
        end
        local_in_valid[c][r] = 1'b0;
    endtask

    task automatic drain_wait(input int limit);
        int waited;
        waited = 0;
        while (pending != 0 && waited < limit) begin
            @(posedge clk);
            #0.5;
            waited++;
        end
        assert (pending == 0) else begin
            failure_note($sformatf("%0d transactions not delivered within %0d cycles",
                                   pending, limit));
        end
    endtask

    // scoreboard fills on accepted input and checks delivered output
    always @(posedge clk) begin : monitor
        common_pkg::t_tile_trans t;
        common_pkg::t_tile_trans exp;
        int k;
        for (int c = LO; c <= HI; c++) begin
            for (int r = LO; r <= HI; r++) begin
                if (!reset && local_in_valid[c][r] && local_in_ready[c][r].ready) begin
                    t = local_in[c][r];
                    if (on_grid(t.target)) begin
                        exp_q[pair_idx(t.origin, t.target)].push_back(t);
                        pending++;
                    end
                end
                if (!reset && local_out_valid[c][r] && local_out_ready[c][r].ready) begin
                    t = local_out[c][r];
                    received++;
                    assert (t.target == tile_id(c, r)) else begin
                        mismatch_error("target", tile_id(c, r), t.target);
                    end
                    assert (on_grid(t.origin)) else begin
                        failure_note("a delivered transaction has an origin outside the grid");
                    end
                    if (t.target == tile_id(c, r) && on_grid(t.origin)) begin
                        k = pair_idx(t.origin, t.target);
                        assert (exp_q[k].size() > 0) else begin
                            failure_note("a transaction arrived that was not sent or came twice");
                        end
                        if (exp_q[k].size() > 0) begin
                            exp = exp_q[k].pop_front();
                            pending--;
                            assert (t == exp) else begin
                                mismatch_error("transaction", exp, t);
                            end
                        end
                    end
                end
            end
        end
    end

    task automatic check_reset_state();
        start_test("reset_state");
        for (int c = LO; c <= HI; c++) begin
            for (int r = LO; r <= HI; r++) begin
                assert (!local_out_valid[c][r]) else begin
                    mismatch_error("local_out_valid", 0, local_out_valid[c][r]);
                end
                assert (local_in_ready[c][r].ready) else begin
                    mismatch_error("local_in_ready", 1, local_in_ready[c][r].ready);
                end
            end
        end
        end_test();
    endtask

    task automatic single_transfers();
        start_test("single_transfers");
        for (int c = LO; c <= HI; c++) begin
            for (int r = LO; r <= HI; r++) begin
                for (int tc = LO; tc <= HI; tc++) begin
                    for (int tr = LO; tr <= HI; tr++) begin
                        send_stream(c, r, tc, tr, 1);
                        drain_wait(50);
                    end
                end
            end
        end
        end_test();
    endtask

    task automatic ordered_burst();
        bit          toggling;
        logic [31:0] coin;
        start_test("ordered_burst");
        toggling = 1'b1;
        fork
            begin
                send_stream(1, 1, 3, 3, 20);
                drain_wait(400);
                toggling = 1'b0;
            end
            while (toggling) begin
                @(posedge clk);
                #0.5;
                coin = lfsr_bits(1);
                local_out_ready[3][3].ready = coin[0];
            end
        join
        local_out_ready[3][3].ready = 1'b1;
        end_test();
    endtask

    task automatic contention();
        start_test("contention");
        for (int c = LO; c <= HI; c++) begin
            for (int r = LO; r <= HI; r++) begin
                fork
                    automatic int fc = c;
                    automatic int fr = r;
                    send_stream(fc, fr, 2, 2, 8);
                join_none
            end
        end
        wait fork;
        drain_wait(600);
        end_test();
    endtask

    task automatic stall_release();
        int cycles;
        bit stalled;
        start_test("stall_release");
        cycles = 0;
        stalled = 1'b0;
        local_out_ready[3][1].ready = 1'b0;
        local_in[1][1] = make_trans(1, 1, 3, 1);
        local_in_valid[1][1] = 1'b1;
        while (!stalled && cycles < 60) begin
            @(posedge clk);
            cycles++;
            stalled = !local_in_ready[1][1].ready;
            #0.5;
            if (!stalled) begin
                local_in[1][1] = make_trans(1, 1, 3, 1);
            end
        end
        assert (stalled) else begin
            failure_note("local_in_ready at [1,1] did not fall within 60 cycles");
        end
        local_out_ready[3][1].ready = 1'b1;
        // the held transaction goes in once the path drains
        @(posedge clk);
        while (!local_in_ready[1][1].ready) begin
            @(posedge clk);
        end
        #0.5;
        local_in_valid[1][1] = 1'b0;
        drain_wait(300);
        end_test();
    endtask

    task automatic edge_sink();
        int seen;
        start_test("edge_sink");
        seen = received;
        // the second of each pair queues behind the first, so an edge that
        // never accepts blocks the [1,1] local queue or the [3,1] west queue
        send_stream(1, 1, 4, 1, 2);
        send_stream(1, 1, 1, 0, 2);
        repeat (30) begin
            @(posedge clk);
        end
        #0.5;
        assert (received == seen) else begin
            failure_note("a transaction with a target outside the grid was delivered");
        end
        // routed through [3,1] and out of the [1,1] local queue
        send_stream(1, 1, 3, 3, 1);
        drain_wait(100);
        end_test();
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) begin
            @(posedge clk);
        end
        $display("timeout after %0d cycles in %s", WATCHDOG_CYCLES, cur_test);
        $display("Something failed");
        $finish;
    end

    initial begin : main
        reset = 1'b1;
        local_in_valid = '0;
        local_in = '0;
        local_out_ready = '1;
        for (int c = 1; c <= 3; c++) begin
            for (int r = 1; r <= 3; r++) begin
                seq_cnt[c][r] = '0;
            end
        end
        repeat (10) begin
            @(posedge clk);
        end
        #0.5;
        reset = 1'b0;
        check_reset_state();
        single_transfers();
        ordered_burst();
        contention();
        stall_release();
        edge_sink();
        $display("tests %0d, failed %0d, errors %0d, delivered %0d",
                 tests_run, failed_tests, errors, received);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/fabric_clk_gen.sv
// testbench clock source
`timescale 1ns/100ps
`default_nettype none

module fabric_clk_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end
endmodule

`default_nettype wire

// File: hdl/fabric.sv
// 3x3 mesh fabric
`timescale 1ns/100ps
`default_nettype none

module fabric #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                               clk,
    input  logic                               reset,
    // core ports, indexed [col][row]
    input  logic                    [3:1][3:1] local_in_valid,
    input  common_pkg::t_tile_trans [3:1][3:1] local_in,
    output common_pkg::t_fab_ready  [3:1][3:1] local_in_ready,
    output logic                    [3:1][3:1] local_out_valid,
    output common_pkg::t_tile_trans [3:1][3:1] local_out,
    input  common_pkg::t_fab_ready  [3:1][3:1] local_out_ready
);
    localparam int LO = common_pkg::GRID_MIN;
    localparam int HI = common_pkg::GRID_MAX;
    localparam int N  = common_pkg::NUM_DIRS;

    // per tile and port, seen from the tile
    logic                    [HI:LO][HI:LO][N-1:0] tile_in_valid;
    common_pkg::t_tile_trans [HI:LO][HI:LO][N-1:0] tile_in;
    common_pkg::t_fab_ready  [HI:LO][HI:LO][N-1:0] tile_in_ready;
    logic                    [HI:LO][HI:LO][N-1:0] tile_out_valid;
    common_pkg::t_tile_trans [HI:LO][HI:LO][N-1:0] tile_out;
    common_pkg::t_fab_ready  [HI:LO][HI:LO][N-1:0] tile_out_ready;

    // tile outputs and input readies with a spare ring around the grid
    logic                    [HI+1:LO-1][HI+1:LO-1][N-1:0] ring_valid;
    common_pkg::t_tile_trans [HI+1:LO-1][HI+1:LO-1][N-1:0] ring_trans;
    common_pkg::t_fab_ready  [HI+1:LO-1][HI+1:LO-1][N-1:0] ring_ready;

    always_comb begin : pad_ring
        // the ring never sends and always accepts
        for (int c = LO - 1; c <= HI + 1; c++) begin
            for (int r = LO - 1; r <= HI + 1; r++) begin
                for (int d = 0; d < N; d++) begin
                    ring_valid[c][r][d] = 1'b0;
                    ring_trans[c][r][d] = '0;
                    ring_ready[c][r][d] = '{ready: 1'b1};
                end
            end
        end
        for (int c = LO; c <= HI; c++) begin
            for (int r = LO; r <= HI; r++) begin
                ring_valid[c][r] = tile_out_valid[c][r];
                ring_trans[c][r] = tile_out[c][r];
                ring_ready[c][r] = tile_in_ready[c][r];
            end
        end
    end

    // each port pairs with the opposite port of the neighbour
    always_comb begin : link_tiles
        for (int c = LO; c <= HI; c++) begin
            for (int r = LO; r <= HI; r++) begin
                tile_in_valid[c][r][common_pkg::LOCAL]  = local_in_valid[c][r];
                tile_in[c][r][common_pkg::LOCAL]        = local_in[c][r];
                tile_out_ready[c][r][common_pkg::LOCAL] = local_out_ready[c][r];
                local_in_ready[c][r]  = tile_in_ready[c][r][common_pkg::LOCAL];
                local_out_valid[c][r] = tile_out_valid[c][r][common_pkg::LOCAL];
                local_out[c][r]       = tile_out[c][r][common_pkg::LOCAL];
                // tile above
                tile_in_valid[c][r][common_pkg::NORTH]  = ring_valid[c][r-1][common_pkg::SOUTH];
                tile_in[c][r][common_pkg::NORTH]        = ring_trans[c][r-1][common_pkg::SOUTH];
                tile_out_ready[c][r][common_pkg::NORTH] = ring_ready[c][r-1][common_pkg::SOUTH];
                // tile below
                tile_in_valid[c][r][common_pkg::SOUTH]  = ring_valid[c][r+1][common_pkg::NORTH];
                tile_in[c][r][common_pkg::SOUTH]        = ring_trans[c][r+1][common_pkg::NORTH];
                tile_out_ready[c][r][common_pkg::SOUTH] = ring_ready[c][r+1][common_pkg::NORTH];
                // tile to the right
                tile_in_valid[c][r][common_pkg::EAST]  = ring_valid[c+1][r][common_pkg::WEST];
                tile_in[c][r][common_pkg::EAST]        = ring_trans[c+1][r][common_pkg::WEST];
                tile_out_ready[c][r][common_pkg::EAST] = ring_ready[c+1][r][common_pkg::WEST];
                // tile to the left
                tile_in_valid[c][r][common_pkg::WEST]  = ring_valid[c-1][r][common_pkg::EAST];
                tile_in[c][r][common_pkg::WEST]        = ring_trans[c-1][r][common_pkg::EAST];
                tile_out_ready[c][r][common_pkg::WEST] = ring_ready[c-1][r][common_pkg::EAST];
            end
        end
    end

    for (genvar col = LO; col <= HI; col++) begin : g_col
        for (genvar row = LO; row <= HI; row++) begin : g_row
            mini_core_tile #(
                .FIFO_DEPTH (FIFO_DEPTH)
            ) mini_core_tile_inst (
                .clk                 (clk),
                .reset               (reset),
                .local_tile_id       (common_pkg::t_tile_id'{col: 4'(col), row: 4'(row)}),
                .in_north_req_valid  (tile_in_valid[col][row][common_pkg::NORTH]),
                .in_north_req        (tile_in[col][row][common_pkg::NORTH]),
                .in_north_ready      (tile_in_ready[col][row][common_pkg::NORTH]),
                .out_north_req_valid (tile_out_valid[col][row][common_pkg::NORTH]),
                .out_north_req       (tile_out[col][row][common_pkg::NORTH]),
                .out_north_ready     (tile_out_ready[col][row][common_pkg::NORTH]),
                .in_east_req_valid   (tile_in_valid[col][row][common_pkg::EAST]),
                .in_east_req         (tile_in[col][row][common_pkg::EAST]),
                .in_east_ready       (tile_in_ready[col][row][common_pkg::EAST]),
                .out_east_req_valid  (tile_out_valid[col][row][common_pkg::EAST]),
                .out_east_req        (tile_out[col][row][common_pkg::EAST]),
                .out_east_ready      (tile_out_ready[col][row][common_pkg::EAST]),
                .in_south_req_valid  (tile_in_valid[col][row][common_pkg::SOUTH]),
                .in_south_req        (tile_in[col][row][common_pkg::SOUTH]),
                .in_south_ready      (tile_in_ready[col][row][common_pkg::SOUTH]),
                .out_south_req_valid (tile_out_valid[col][row][common_pkg::SOUTH]),
                .out_south_req       (tile_out[col][row][common_pkg::SOUTH]),
                .out_south_ready     (tile_out_ready[col][row][common_pkg::SOUTH]),
                .in_west_req_valid   (tile_in_valid[col][row][common_pkg::WEST]),
                .in_west_req         (tile_in[col][row][common_pkg::WEST]),
                .in_west_ready       (tile_in_ready[col][row][common_pkg::WEST]),
                .out_west_req_valid  (tile_out_valid[col][row][common_pkg::WEST]),
                .out_west_req        (tile_out[col][row][common_pkg::WEST]),
                .out_west_ready      (tile_out_ready[col][row][common_pkg::WEST]),
                .in_local_req_valid  (tile_in_valid[col][row][common_pkg::LOCAL]),
                .in_local_req        (tile_in[col][row][common_pkg::LOCAL]),
                .in_local_ready      (tile_in_ready[col][row][common_pkg::LOCAL]),
                .out_local_req_valid (tile_out_valid[col][row][common_pkg::LOCAL]),
                .out_local_req       (tile_out[col][row][common_pkg::LOCAL]),
                .out_local_ready     (tile_out_ready[col][row][common_pkg::LOCAL])
            );
        end
    end

endmodule

`default_nettype wire

// File: hdl/mini_core_tile.sv
// mesh router tile
`timescale 1ns/100ps
`default_nettype none

module mini_core_tile #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  common_pkg::t_tile_id    local_tile_id,
    // north
    input  logic                    in_north_req_valid,
    input  common_pkg::t_tile_trans in_north_req,
    output common_pkg::t_fab_ready  in_north_ready,
    output logic                    out_north_req_valid,
    output common_pkg::t_tile_trans out_north_req,
    input  common_pkg::t_fab_ready  out_north_ready,
    // east
    input  logic                    in_east_req_valid,
    input  common_pkg::t_tile_trans in_east_req,
    output common_pkg::t_fab_ready  in_east_ready,
    output logic                    out_east_req_valid,
    output common_pkg::t_tile_trans out_east_req,
    input  common_pkg::t_fab_ready  out_east_ready,
    // south
    input  logic                    in_south_req_valid,
    input  common_pkg::t_tile_trans in_south_req,
    output common_pkg::t_fab_ready  in_south_ready,
    output logic                    out_south_req_valid,
    output common_pkg::t_tile_trans out_south_req,
    input  common_pkg::t_fab_ready  out_south_ready,
    // west
    input  logic                    in_west_req_valid,
    input  common_pkg::t_tile_trans in_west_req,
    output common_pkg::t_fab_ready  in_west_ready,
    output logic                    out_west_req_valid,
    output common_pkg::t_tile_trans out_west_req,
    input  common_pkg::t_fab_ready  out_west_ready,
    // core port
    input  logic                    in_local_req_valid,
    input  common_pkg::t_tile_trans in_local_req,
    output common_pkg::t_fab_ready  in_local_ready,
    output logic                    out_local_req_valid,
    output common_pkg::t_tile_trans out_local_req,
    input  common_pkg::t_fab_ready  out_local_ready
);
    localparam int N = common_pkg::NUM_DIRS;

    logic                    [N-1:0] in_valid;
    common_pkg::t_tile_trans [N-1:0] in_trans;
    common_pkg::t_fab_ready  [N-1:0] in_ready;
    logic                    [N-1:0] head_valid;
    common_pkg::t_tile_trans [N-1:0] head_trans;
    logic                    [N-1:0] pop;
    logic                    [N-1:0] out_valid;
    common_pkg::t_tile_trans [N-1:0] out_trans;
    common_pkg::t_fab_ready  [N-1:0] out_ready;

    // concatenations run WEST down to LOCAL, matching t_dir
    assign in_valid = {in_west_req_valid, in_south_req_valid, in_east_req_valid,
                       in_north_req_valid, in_local_req_valid};
    assign in_trans = {in_west_req, in_south_req, in_east_req, in_north_req, in_local_req};
    assign out_ready = {out_west_ready, out_south_ready, out_east_ready,
                        out_north_ready, out_local_ready};
    assign {in_west_ready, in_south_ready, in_east_ready, in_north_ready, in_local_ready} =
        in_ready;
    assign {out_west_req_valid, out_south_req_valid, out_east_req_valid,
            out_north_req_valid, out_local_req_valid} = out_valid;
    assign {out_west_req, out_south_req, out_east_req, out_north_req, out_local_req} =
        out_trans;

    for (genvar d = 0; d < N; d++) begin : g_queue
        tile_in_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) tile_in_fifo_inst (
            .clk        (clk),
            .reset      (reset),
            .in_valid   (in_valid[d]),
            .in_trans   (in_trans[d]),
            .in_ready   (in_ready[d]),
            .head_valid (head_valid[d]),
            .head_trans (head_trans[d]),
            .pop        (pop[d])
        );
    end

    tile_xbar tile_xbar_inst (
        .clk           (clk),
        .reset         (reset),
        .local_tile_id (local_tile_id),
        .head_valid    (head_valid),
        .head_trans    (head_trans),
        .pop           (pop),
        .out_valid     (out_valid),
        .out_trans     (out_trans),
        .out_ready     (out_ready)
    );

endmodule

`default_nettype wire

// File: hdl/tile_xbar.sv
// router crossbar and output arbiters
`timescale 1ns/100ps
`default_nettype none

module tile_xbar (
    input  logic                                               clk,
    input  logic                                               reset,
    input  common_pkg::t_tile_id                               local_tile_id,
    input  logic                    [common_pkg::NUM_DIRS-1:0] head_valid,
    input  common_pkg::t_tile_trans [common_pkg::NUM_DIRS-1:0] head_trans,
    output logic                    [common_pkg::NUM_DIRS-1:0] pop,
    output logic                    [common_pkg::NUM_DIRS-1:0] out_valid,
    output common_pkg::t_tile_trans [common_pkg::NUM_DIRS-1:0] out_trans,
    input  common_pkg::t_fab_ready  [common_pkg::NUM_DIRS-1:0] out_ready
);
    localparam int N     = common_pkg::NUM_DIRS;
    localparam int DIR_W = $clog2(N);

    common_pkg::t_dir         route_dir [N];
    // request matrix, [output][input]
    logic [N-1:0][N-1:0]      req;
    logic [N-1:0]             load_ok;
    logic [N-1:0]             win_any;
    logic [N-1:0][DIR_W-1:0]  win_idx;
    logic [N-1:0][DIR_W-1:0]  rr_ptr;

    // dimension order, column first and then row
    function automatic common_pkg::t_dir route_of(
        input common_pkg::t_tile_id target,
        input common_pkg::t_tile_id own
    );
        if (target.col > own.col) begin
            return common_pkg::EAST;
        end else if (target.col < own.col) begin
            return common_pkg::WEST;
        end else if (target.row > own.row) begin
            return common_pkg::SOUTH;
        end else if (target.row < own.row) begin
            return common_pkg::NORTH;
        end
        return common_pkg::LOCAL;
    endfunction

    always_comb begin : route_req
        for (int i = 0; i < N; i++) begin
            route_dir[i] = route_of(head_trans[i].target, local_tile_id);
        end
        for (int o = 0; o < N; o++) begin
            for (int i = 0; i < N; i++) begin
                req[o][i] = head_valid[i] && (int'(route_dir[i]) == o);
            end
        end
    end

    always_comb begin : arbitrate
        int idx;
        win_any = '0;
        win_idx = '0;
        pop     = '0;
        for (int o = 0; o < N; o++) begin
            // register is free or drains on this edge
            load_ok[o] = !out_valid[o] || out_ready[o].ready;
            // walk backwards so the input nearest the pointer wins last
            for (int k = N - 1; k >= 0; k--) begin
                idx = int'(rr_ptr[o]) + k;
                if (idx >= N) begin
                    idx = idx - N;
                end
                if (req[o][idx]) begin
                    win_any[o] = 1'b1;
                    win_idx[o] = DIR_W'(idx);
                end
            end
        end
        for (int o = 0; o < N; o++) begin
            if (win_any[o] && load_ok[o]) begin
                pop[win_idx[o]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin : out_ctrl
        if (reset) begin
            out_valid <= '0;
            for (int o = 0; o < N; o++) begin
                rr_ptr[o] <= DIR_W'(common_pkg::LOCAL);
            end
        end else begin
            for (int o = 0; o < N; o++) begin
                if (load_ok[o]) begin
                    out_valid[o] <= win_any[o];
                end
                // priority moves to the input after the winner
                if (load_ok[o] && win_any[o]) begin
                    rr_ptr[o] <= (win_idx[o] == DIR_W'(N - 1)) ? '0 : win_idx[o] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin : out_data
        for (int o = 0; o < N; o++) begin
            if (load_ok[o] && win_any[o]) begin
                out_trans[o] <= head_trans[win_idx[o]];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/tile_in_fifo.sv
// router input queue
`timescale 1ns/100ps
`default_nettype none

module tile_in_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  common_pkg::t_tile_trans in_trans,
    output common_pkg::t_fab_ready  in_ready,
    output logic                    head_valid,
    output common_pkg::t_tile_trans head_trans,
    input  logic                    pop
);
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    common_pkg::t_tile_trans mem [FIFO_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [CNT_W-1:0]        count;
    logic                    push;
    logic                    drain;

    // wraps at FIFO_DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ready only looks at our own fill level
    assign in_ready   = '{ready: (count != CNT_W'(FIFO_DEPTH))};
    assign push       = in_valid && in_ready.ready;
    assign drain      = pop && head_valid;
    assign head_valid = (count != '0);
    assign head_trans = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (drain) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // push and drain together leave the count unchanged
            case ({push, drain})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_trans;
        end
    end

endmodule

`default_nettype wire

// File: hdl/common_pkg.sv
// fabric shared types
`default_nettype none

package common_pkg;

    // valid grid coordinates run from GRID_MIN to GRID_MAX
    localparam int GRID_MIN = 1;
    localparam int GRID_MAX = 3;

    // router ports per tile
    localparam int NUM_DIRS = 5;

    // tile coordinate
    // row 1 is the top row and column 1 the left column
    typedef struct packed {
        logic [3:0] col;
        logic [3:0] row;
    } t_tile_id;

    // one transaction on a link, 56 bits in all
    typedef struct packed {
        t_tile_id    target;
        t_tile_id    origin;
        logic [7:0]  seq;
        logic [31:0] data;
    } t_tile_trans;

    // level driven back by the receiver of a link
    typedef struct packed {
        logic ready;
    } t_fab_ready;

    // port index inside a tile
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        NORTH = 3'd1,
        EAST  = 3'd2,
        SOUTH = 3'd3,
        WEST  = 3'd4
    } t_dir;

endpackage

`default_nettype wire
